//--- src.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/branch_predecode.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
verif/fetch_props.sv
verif/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module fetch_tb -Mdir obj_dir

# the log decides the result, not the exit code
./obj_dir/Vfetch_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
	echo "simulation run passed"
else
	echo "simulation run failed, see sim.log"
	exit 1
fi

//--- verif/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_tb;

	localparam int NUM_PKTS    = 400;
	localparam int MEM_WORDS   = 256;
	localparam int WATCHDOG_NS = NUM_PKTS * 20 * 4;

	logic                  clk;
	logic                  rst;
	fetch_pkg::redirect_t  redirect;
	logic                  fence_i;
	logic                  out_valid;
	fetch_pkg::fetch_pkt_t out_pkt;
	logic                  out_ready;
	logic                  arvalid;
	fetch_pkg::axil_ar_t   ar;
	logic                  arready;
	logic                  rvalid;
	fetch_pkg::axil_r_t    r;
	logic                  rready;

	// program image and the walk it implies
	logic [31:0] mem_word [MEM_WORDS];
	int          next_idx [MEM_WORDS];
	logic        taken    [MEM_WORDS];

	// model of cache valid/tag
	logic [15:0] model_valid;
	logic [56:0] model_tag [16];

	logic [31:0] lcg_state;
	int          errors;
	int          packets;
	int          exp_idx;
	int          ar_count;
	logic        hit_next;
	logic        skip_hit;
	int          next_fence;

	// axi slave state
	logic [63:0] rd_addr;
	logic        rd_busy;
	int          ar_wait;
	int          r_wait;

	fetch_top u_fetch_top (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.fence_i(fence_i),
		.out_valid(out_valid),
		.out_pkt(out_pkt),
		.out_ready(out_ready),
		.arvalid(arvalid),
		.ar(ar),
		.arready(arready),
		.rvalid(rvalid),
		.r(r),
		.rready(rready)
	);

	always #2 clk = ~clk;

	// **************************************************
	// helpers
	// **************************************************
	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		// low lcg bits repeat fast
		return {8'd0, lcg_state[31:8]};
	endfunction

	function automatic logic [63:0] idx_to_pc(input int idx);
		return `FETCH_RESET_PC + 64'(idx) * 64'd4;
	endfunction

	function automatic logic model_hit(input int idx);
		logic [63:0] a;
		a = idx_to_pc(idx);
		return model_valid[a[6:3]] && (model_tag[a[6:3]] == a[63:7]);
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		$display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR: %s", what);
		errors++;
	endtask

	// plain words, jal, and branches both ways with all targets inside
	task automatic build_memory();
		int          sel;
		int          t;
		logic [31:0] rnd;
		logic [31:0] ofs;
		for (int i = 0; i < MEM_WORDS; i++) begin
			sel = (i == MEM_WORDS - 1) ? 4 : int'(next_rand() % 8);
			t   = int'(next_rand() % MEM_WORDS);
			if (t == i) begin
				t = (i + 1) % MEM_WORDS;
			end
			rnd = next_rand();
			ofs = (t - i) * 4;
			next_idx[i] = i + 1;
			taken[i]    = 1'b0;
			if (sel == 4) begin
				mem_word[i] = {ofs[20], ofs[10:1], ofs[11], ofs[19:12], 5'd1, 7'b1101111};
				next_idx[i] = t;
				taken[i]    = 1'b1;
			end else if (sel == 5 || sel == 6) begin
				mem_word[i] = {ofs[12], ofs[10:5], rnd[9:5], rnd[4:0], 3'b001, ofs[4:1],
					ofs[11], 7'b1100011};
				// only a back edge is predicted
				if (t < i) begin
					next_idx[i] = t;
					taken[i]    = 1'b1;
				end
			end else begin
				mem_word[i] = {rnd[23:0], 1'b0, 7'b0010011};
			end
		end
	endtask

	// **************************************************
	// per-packet check against the walk
	// **************************************************
	task automatic check_packet();
		if (out_pkt.pc != idx_to_pc(exp_idx)) begin
			report_mismatch("packet pc", idx_to_pc(exp_idx), out_pkt.pc);
		end
		if (out_pkt.inst != mem_word[exp_idx]) begin
			report_mismatch("instruction word", 64'(mem_word[exp_idx]), 64'(out_pkt.inst));
		end
		if (out_pkt.pred_taken != taken[exp_idx]) begin
			report_mismatch("pred_taken", 64'(taken[exp_idx]), 64'(out_pkt.pred_taken));
		end
		// miss costs exactly one AR, hit none
		if (!skip_hit && (ar_count != (hit_next ? 0 : 1))) begin
			report_mismatch("refill count", 64'(hit_next ? 0 : 1), 64'(ar_count));
		end
		exp_idx  = next_idx[exp_idx];
		hit_next = model_hit(exp_idx);
		skip_hit = 1'b0;
		ar_count = 0;
		packets++;
	endtask

	// sample at negedge, drive 0.5 ns after the rising edge
	task automatic step_cycle();
		logic        ar_hs;
		logic        r_hs;
		logic [63:0] ar_addr;
		logic [63:0] ofs64;
		int          ridx;
		@(negedge clk);
		ar_hs   = arvalid && arready;
		r_hs    = rvalid && rready;
		ar_addr = ar.araddr;
		if (out_valid && out_ready) begin
			check_packet();
		end
		if (ar_hs && (ar.arprot != `FETCH_AXI_PROT_INST)) begin
			report_mismatch("arprot", 64'(`FETCH_AXI_PROT_INST), 64'(ar.arprot));
		end
		@(posedge clk);
		#0.5;
		// AR channel with 0 to 3 cycles of arready delay
		if (ar_hs) begin
			ar_count++;
			rd_addr = ar_addr;
			rd_busy = 1'b1;
			arready = 1'b0;
			ar_wait = int'(next_rand() % 4);
			r_wait  = int'(next_rand() % 4);
		end else if (arvalid && !rd_busy) begin
			if (ar_wait == 0) begin
				arready = 1'b1;
			end else begin
				ar_wait--;
			end
		end
		// R channel puts the line in the model on the handshake
		if (r_hs) begin
			rvalid  = 1'b0;
			rd_busy = 1'b0;
			model_valid[rd_addr[6:3]] = 1'b1;
			model_tag[rd_addr[6:3]]   = rd_addr[63:7];
		end else if (rd_busy && !rvalid) begin
			if (r_wait > 0) begin
				r_wait--;
			end else begin
				ofs64 = rd_addr - `FETCH_RESET_PC;
				ridx  = 0;
				if ((ofs64 >= 64'd1024) || (rd_addr[2:0] != 3'b000)) begin
					report_problem("refill read outside the program memory");
				end else begin
					ridx = int'(ofs64[9:2]);
				end
				r = '{rdata: {mem_word[ridx + 1], mem_word[ridx]},
					rresp: `FETCH_AXI_RESP_OKAY};
				rvalid = 1'b1;
			end
		end
	endtask

	// new word, fence, then redirect onto it
	task automatic run_fence_test();
		int          k;
		logic [31:0] rnd;
		// word of the held packet, whose line is surely cached
		k   = (exp_idx == MEM_WORDS - 1) ? exp_idx - 1 : exp_idx;
		rnd = next_rand();
		mem_word[k] = {rnd[23:0], 1'b1, 7'b0010011};
		next_idx[k] = k + 1;
		taken[k]    = 1'b0;
		out_ready   = 1'b0;
		fence_i     = 1'b1;
		model_valid = '0;
		step_cycle();
		fence_i  = 1'b0;
		redirect = '{valid: 1'b1, target: idx_to_pc(k)};
		exp_idx  = k;
		// all lines gone, so this must miss
		skip_hit   = 1'b0;
		hit_next   = 1'b0;
		ar_count   = 0;
		next_fence = next_fence + 100;
	endtask

	task automatic drive_decode();
		int k;
		redirect = '0;
		fence_i  = 1'b0;
		if (packets >= next_fence && out_valid && !rd_busy && !arvalid) begin
			run_fence_test();
		end else if (next_rand() % 24 == 0) begin
			k         = int'(next_rand() % MEM_WORDS);
			out_ready = 1'b0;
			redirect  = '{valid: 1'b1, target: idx_to_pc(k)};
			exp_idx   = k;
			// a dropped refill may still land in this window
			skip_hit  = 1'b1;
			ar_count  = 0;
		end else begin
			out_ready = (next_rand() % 4) != 0;
		end
	endtask

	// **************************************************
	// main sequence and watchdog
	// **************************************************
	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		redirect    = '0;
		fence_i     = 1'b0;
		out_ready   = 1'b0;
		arready     = 1'b0;
		rvalid      = 1'b0;
		r           = '0;
		lcg_state   = 32'd15;
		errors      = 0;
		packets     = 0;
		exp_idx     = 0;
		ar_count    = 0;
		hit_next    = 1'b0;
		skip_hit    = 1'b0;
		next_fence  = 100;
		model_valid = '0;
		rd_addr     = '0;
		rd_busy     = 1'b0;
		ar_wait     = 0;
		r_wait      = 0;
		build_memory();
		repeat (5) @(posedge clk);
		#0.5;
		rst = 1'b0;
		while (packets < NUM_PKTS) begin
			step_cycle();
			drive_decode();
		end
		$display("fetch_tb summary: %0d packets, %0d check errors, %0d assertion errors",
			packets, errors, u_fetch_top.u_fetch_props.fail_count);
		if ((errors == 0) && (u_fetch_top.u_fetch_props.fail_count == 0)) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired with %0d of %0d packets taken", packets, NUM_PKTS);
		$display("fetch_tb summary: %0d packets, %0d check errors", packets, errors);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/fetch_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_props (
	input wire                         clk,
	input wire                         rst,
	input wire                         arvalid,
	input wire                         arready,
	input wire fetch_pkg::axil_ar_t    ar,
	input wire                         out_valid,
	input wire                         out_ready,
	input wire fetch_pkg::fetch_pkt_t  out_pkt,
	input wire                         redirect_valid,
	input wire                         rsp_valid,
	input wire                         rvalid,
	input wire                         rready,
	input wire fetch_pkg::cache_state_e cache_state
);

	// per-property failure tallies
	int ar_fails  = 0;
	int pkt_fails = 0;
	int rst_fails = 0;
	int rsp_fails = 0;
	int fail_count;

	assign fail_count = ar_fails + pkt_fails + rst_fails + rsp_fails;

	// **************************************************
	// axi read address channel
	// **************************************************
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		(arvalid && !arready) |=> (arvalid && $stable(ar)))
		else begin
			ar_fails++;
			$error("ar dropped or changed before arready");
		end

	// quiet bus right after reset
	ar_after_rst: assert property (@(posedge clk) rst |=> !arvalid)
		else begin
			rst_fails++;
			$error("arvalid high in the cycle after reset");
		end

	// **************************************************
	// decode port and cache response
	// **************************************************

	// redirect is the only way out of a stall
	pkt_hold: assert property (@(posedge clk) disable iff (rst)
		(out_valid && !out_ready && !redirect_valid) |=> (out_valid && $stable(out_pkt)))
		else begin
			pkt_fails++;
			$error("out_pkt changed under back-pressure");
		end

	// hit in lookup, or forwarded straight after R
	rsp_source: assert property (@(posedge clk) disable iff (rst)
		rsp_valid |-> ($past(cache_state == fetch_pkg::st_lookup) || $past(rvalid && rready)))
		else begin
			rsp_fails++;
			$error("rsp_valid outside lookup and not after an R handshake");
		end

endmodule

bind fetch_top fetch_props u_fetch_props (
	.clk(clk),
	.rst(rst),
	.arvalid(arvalid),
	.arready(arready),
	.ar(ar),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_pkt(out_pkt),
	.redirect_valid(redirect.valid),
	.rsp_valid(rsp_valid),
	.rvalid(rvalid),
	.rready(rready),
	.cache_state(u_icache.state)
);

`default_nettype wire

//--- hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_top (
	input  wire                         clk,
	input  wire                         rst,
	input  wire fetch_pkg::redirect_t   redirect,
	input  wire                         fence_i,
	output logic                        out_valid,
	output fetch_pkg::fetch_pkt_t       out_pkt,
	input  wire                         out_ready,
	output logic                        arvalid,
	output fetch_pkg::axil_ar_t         ar,
	input  wire                         arready,
	input  wire                         rvalid,
	input  wire fetch_pkg::axil_r_t     r,
	output logic                        rready
);

	// fetch unit <-> cache
	logic                     req_valid;
	fetch_pkg::cache_req_t    req;
	logic                     req_ready;
	logic                     rsp_valid;
	fetch_pkg::cache_rsp_t    rsp;
	logic                     redirect_flush;

	// fetch unit <-> pre-decode
	logic [31:0]              pd_inst;
	logic [`FETCH_ADDR_W-1:0] pd_pc;
	logic [`FETCH_ADDR_W-1:0] pd_next_pc;
	logic                     pd_taken;

	fetch_unit u_fetch_unit (
		.clk(clk), .rst(rst), .redirect(redirect),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp(rsp),
		.pd_inst(pd_inst), .pd_pc(pd_pc), .pd_next_pc(pd_next_pc), .pd_taken(pd_taken),
		.out_valid(out_valid), .out_pkt(out_pkt), .out_ready(out_ready),
		.redirect_flush(redirect_flush)
	);

	// kind only drives the prediction inside
	branch_predecode u_branch_predecode (
		.inst(pd_inst), .pc(pd_pc), .kind(), .pred_taken(pd_taken), .next_pc(pd_next_pc)
	);

	icache u_icache (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp(rsp),
		.redirect_flush(redirect_flush), .fence_i(fence_i),
		.arvalid(arvalid), .ar(ar), .arready(arready),
		.rvalid(rvalid), .r(r), .rready(rready)
	);

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module fetch_unit (
	input  wire                         clk,
	input  wire                         rst,
	input  wire fetch_pkg::redirect_t   redirect,
	output logic                        req_valid,
	output fetch_pkg::cache_req_t       req,
	input  wire                         req_ready,
	input  wire                         rsp_valid,
	input  wire fetch_pkg::cache_rsp_t  rsp,
	output logic [31:0]                 pd_inst,
	output logic [`FETCH_ADDR_W-1:0]    pd_pc,
	input  wire  [`FETCH_ADDR_W-1:0]    pd_next_pc,
	input  wire                         pd_taken,
	output logic                        out_valid,
	output fetch_pkg::fetch_pkt_t       out_pkt,
	input  wire                         out_ready,
	output logic                        redirect_flush
);

	logic [`FETCH_ADDR_W-1:0] pc_q;
	logic [`FETCH_ADDR_W-1:0] pc_next;
	// request accepted by cache, word not back yet
	logic                     pending;
	logic                     req_fire;
	logic                     rsp_take;
	logic                     out_fire;

	// cache drops open refills on redirect
	assign redirect_flush = redirect.valid;

	// **************************************************
	// cache request
	// **************************************************

	// one word in flight, and only once decode has the last one
	assign req_valid = !pending && !out_valid && !redirect.valid;
	assign req       = '{pc: pc_q};
	assign req_fire  = req_valid && req_ready;

	// stale word on redirect is ignored
	assign rsp_take = rsp_valid && pending && !redirect.valid;
	assign out_fire = out_valid && out_ready;

	// returned word goes to pre-decode
	assign pd_inst = rsp.inst;
	assign pd_pc   = rsp.pc;

	// redirect, then prediction, then hold
	always_comb begin
		if (redirect.valid) begin
			pc_next = redirect.target;
		end else if (rsp_take) begin
			pc_next = pd_next_pc;
		end else begin
			pc_next = pc_q;
		end
	end

	// **************************************************
	// pc and handshake state
	// **************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q      <= `FETCH_RESET_PC;
			pending   <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			pc_q <= pc_next;
			if (redirect.valid) begin
				// discard whatever decode has not taken
				pending   <= 1'b0;
				out_valid <= 1'b0;
			end else begin
				if (req_fire) begin
					pending <= 1'b1;
				end else if (rsp_take) begin
					pending <= 1'b0;
				end
				if (rsp_take) begin
					out_valid <= 1'b1;
				end else if (out_fire) begin
					out_valid <= 1'b0;
				end
			end
		end
	end

	// output packet holds stable while decode stalls
	always_ff @(posedge clk) begin
		if (rsp_take) begin
			out_pkt <= '{pc: rsp.pc, inst: rsp.inst, pred_taken: pd_taken};
		end
	end

endmodule

`default_nettype wire

//--- hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module icache (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        req_valid,
	input  wire fetch_pkg::cache_req_t req,
	output logic                       req_ready,
	output logic                       rsp_valid,
	output fetch_pkg::cache_rsp_t      rsp,
	input  wire                        redirect_flush,
	input  wire                        fence_i,
	output logic                       arvalid,
	output fetch_pkg::axil_ar_t        ar,
	input  wire                        arready,
	input  wire                        rvalid,
	input  wire fetch_pkg::axil_r_t    r,
	output logic                       rready
);

	localparam int LINES = `FETCH_ICACHE_LINES;
	localparam int IDX_W = $clog2(LINES);
	// byte offset inside one 64-bit line
	localparam int OFS_W = 3;
	localparam int TAG_W = `FETCH_ADDR_W - IDX_W - OFS_W;

	// line storage
	logic [`FETCH_DATA_W-1:0] data_mem [LINES];
	logic [TAG_W-1:0]         tag_mem  [LINES];
	logic [LINES-1:0]         line_valid;

	fetch_pkg::cache_state_e  state;
	logic [`FETCH_ADDR_W-1:0] miss_pc;
	logic                     drop_rsp;
	logic                     fence_pend;

	logic [IDX_W-1:0]         req_idx;
	logic [TAG_W-1:0]         req_tag;
	logic [IDX_W-1:0]         miss_idx;
	logic [TAG_W-1:0]         miss_tag;
	logic [`FETCH_DATA_W-1:0] hit_word;
	logic                     fence_now;
	logic                     hit;
	logic                     lookup_fire;
	logic                     r_fire;
	logic                     r_ok;

	// upper half for pc bit 2 set
	function automatic logic [31:0] pick_half(input logic [`FETCH_DATA_W-1:0] word,
		input logic hi);
		return hi ? word[63:32] : word[31:0];
	endfunction

	// **************************************************
	// lookup
	// **************************************************
	assign req_idx  = req.pc[OFS_W +: IDX_W];
	assign req_tag  = req.pc[`FETCH_ADDR_W-1 -: TAG_W];
	assign miss_idx = miss_pc[OFS_W +: IDX_W];
	assign miss_tag = miss_pc[`FETCH_ADDR_W-1 -: TAG_W];
	assign hit_word = data_mem[req_idx];

	// a fence seen this cycle or held from a refill
	assign fence_now = fence_i || fence_pend;
	// lines about to be wiped never hit
	assign hit = line_valid[req_idx] && (tag_mem[req_idx] == req_tag) && !fence_now;

	assign req_ready   = (state == fetch_pkg::st_lookup);
	assign lookup_fire = req_valid && req_ready;

	// **************************************************
	// axi4-lite read port
	// **************************************************
	assign arvalid = (state == fetch_pkg::st_ar);
	assign rready  = (state == fetch_pkg::st_r);
	assign r_fire  = rvalid && rready;
	// error response leaves the line invalid
	assign r_ok    = (r.rresp == `FETCH_AXI_RESP_OKAY);

	// line aligned, held from the miss register
	always_comb begin
		ar.araddr = {miss_pc[`FETCH_ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
		ar.arprot = `FETCH_AXI_PROT_INST;
	end

	// control
	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= fetch_pkg::st_lookup;
			rsp_valid  <= 1'b0;
			line_valid <= '0;
			drop_rsp   <= 1'b0;
			fence_pend <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				fetch_pkg::st_lookup: begin
					// invalidate everything
					if (fence_now) begin
						line_valid <= '0;
					end
					if (lookup_fire) begin
						if (hit) begin
							rsp_valid <= !redirect_flush;
						end else begin
							state <= fetch_pkg::st_ar;
						end
					end
				end
				fetch_pkg::st_ar: begin
					if (arready) begin
						state <= fetch_pkg::st_r;
					end
				end
				fetch_pkg::st_r: begin
					if (r_fire) begin
						line_valid[miss_idx] <= r_ok;
						// line is kept even when the word is dropped
						rsp_valid <= !(drop_rsp || redirect_flush);
						state     <= fetch_pkg::st_lookup;
					end
				end
				default: state <= fetch_pkg::st_lookup;
			endcase

			// fence during refill waits for lookup
			if (state == fetch_pkg::st_lookup) begin
				fence_pend <= 1'b0;
			end else if (fence_i) begin
				fence_pend <= 1'b1;
			end

			// redirect while a refill is open
			if (state == fetch_pkg::st_lookup) begin
				drop_rsp <= redirect_flush;
			end else if (redirect_flush) begin
				drop_rsp <= 1'b1;
			end
		end
	end

	// payload and arrays
	always_ff @(posedge clk) begin
		if (lookup_fire && !hit) begin
			miss_pc <= req.pc;
		end
		if (r_fire) begin
			data_mem[miss_idx] <= r.rdata;
			tag_mem[miss_idx]  <= miss_tag;
		end
		if (lookup_fire && hit) begin
			rsp <= '{pc: req.pc, inst: pick_half(hit_word, req.pc[2])};
		end else if (r_fire) begin
			// forward straight from the bus
			rsp <= '{pc: miss_pc, inst: pick_half(r.rdata, miss_pc[2])};
		end
	end

endmodule

`default_nettype wire

//--- hdl/branch_predecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_config.svh"

module branch_predecode (
	input  wire  [31:0]               inst,
	input  wire  [`FETCH_ADDR_W-1:0]  pc,
	output fetch_pkg::inst_kind_e     kind,
	output logic                      pred_taken,
	output logic [`FETCH_ADDR_W-1:0]  next_pc
);

	logic [`FETCH_ADDR_W-1:0] imm_b;
	logic [`FETCH_ADDR_W-1:0] imm_j;
	logic                     backward;

	// **************************************************
	// immediates
	// **************************************************

	// b-type immediate with sign from bit 31 and bit 0 always zero
	assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	// j-type immediate takes the same sign bit over a 21-bit range
	assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// negative offset means a loop back edge
	assign backward = inst[31];

	// sort by major opcode only
	always_comb begin
		case (inst[6:0])
			fetch_pkg::op_jal:    kind = fetch_pkg::kind_jal;
			fetch_pkg::op_branch: kind = fetch_pkg::kind_branch;
			default:              kind = fetch_pkg::kind_seq;
		endcase
	end

	// jal always taken, branch only when backward
	assign pred_taken = (kind == fetch_pkg::kind_jal)
		|| ((kind == fetch_pkg::kind_branch) && backward);

	// **************************************************
	// predicted next pc
	// **************************************************
	always_comb begin
		case (kind)
			fetch_pkg::kind_jal:    next_pc = pc + imm_j;
			fetch_pkg::kind_branch: next_pc = backward ? (pc + imm_b) : (pc + 64'd4);
			default:                next_pc = pc + 64'd4;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/fetch_pkg.sv
`default_nettype none
`include "fetch_config.svh"

package fetch_pkg;

	// packet handed to decode
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] pc;
		logic [31:0]              inst;
		logic                     pred_taken;
	} fetch_pkt_t;

	// pc correction from execute
	typedef struct packed {
		logic                     valid;
		logic [`FETCH_ADDR_W-1:0] target;
	} redirect_t;

	// fetch unit to cache
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] pc;
	} cache_req_t;

	// cache to fetch unit, one 32-bit word
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] pc;
		logic [31:0]              inst;
	} cache_rsp_t;

	// axi4-lite read address and read data payloads
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] araddr;
		logic [2:0]               arprot;
	} axil_ar_t;

	typedef struct packed {
		logic [`FETCH_DATA_W-1:0] rdata;
		logic [1:0]               rresp;
	} axil_r_t;

	// rv major opcodes the predictor cares about
	typedef enum logic [6:0] {op_branch = 7'b1100011, op_jal = 7'b1101111} opcode_e;

	typedef enum logic [1:0] {kind_seq, kind_jal, kind_branch} inst_kind_e;

	typedef enum logic [1:0] {st_lookup, st_ar, st_r} cache_state_e;

endpackage

`default_nettype wire

//--- hdl/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 64'h80000000

// direct mapped with one 8-byte word per line
`define FETCH_ICACHE_LINES 16

// address and memory data widths
`define FETCH_ADDR_W 64
`define FETCH_DATA_W 64

// fetch arprot marks an instruction, secure, unprivileged access
`define FETCH_AXI_PROT_INST 3'b100

// rresp encoding for a good read
`define FETCH_AXI_RESP_OKAY 2'b00

`endif
